// File: hw/replay_pkg.sv
// ==========================================================================
// Miss replay queue shared definitions
// ==========================================================================

package replay_pkg;

  // queue geometry
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_WIDTH  = 2;
  localparam int CNT_WIDTH   = 3;

  // memory op fields
  localparam int VADDR_WIDTH       = 44;
  localparam int PAGE_OFFSET_WIDTH = 14;
  localparam int PAGE_WIDTH        = 30;
  localparam int SZ_WIDTH          = 5;
  localparam int ATTR_WIDTH        = 4;
  localparam int LSQ_WIDTH         = 9;

  // head processing states
  localparam int STATE_WIDTH = 2;
  localparam logic [STATE_WIDTH-1:0] ST_SETTLE = 2'd0;
  localparam logic [STATE_WIDTH-1:0] ST_REQ0   = 2'd1;
  localparam logic [STATE_WIDTH-1:0] ST_REQ1   = 2'd2;
  localparam logic [STATE_WIDTH-1:0] ST_BEAT   = 2'd3;

  // virtual address, flat or as page number plus offset
  typedef union packed {
    logic [VADDR_WIDTH-1:0] raw;
    struct packed {
      logic [PAGE_WIDTH-1:0]        page;
      logic [PAGE_OFFSET_WIDTH-1:0] offset;
    } split;
  } vaddr_u;

endpackage

// File: hw/mop_lane_if.sv
// ==========================================================================
// One lane memory op
// ==========================================================================

`timescale 1ns/100ps

interface mop_lane_if;

  logic                              en;
  logic                              thread;
  replay_pkg::vaddr_u                addr;
  logic [replay_pkg::SZ_WIDTH-1:0]   sz;
  logic [replay_pkg::ATTR_WIDTH-1:0] attr;
  logic [replay_pkg::LSQ_WIDTH-1:0]  lsq;

  // producer side
  modport src (
    output en,
    output thread,
    output addr,
    output sz,
    output attr,
    output lsq
  );

  // consumer side
  modport dst (
    input en,
    input thread,
    input addr,
    input sz,
    input attr,
    input lsq
  );

endinterface

// File: hw/miss_replay_lane.sv
// ==========================================================================
// Miss replay lane storage and output select
// ==========================================================================

`timescale 1ns/100ps

module miss_replay_lane (
  input  logic                                  clk,
  input  logic                                  rst,
  mop_lane_if.dst                               op_i,
  mop_lane_if.src                               op_o,
  input  logic                                  miss_i,
  input  logic                                  wr_en_i,
  input  logic [replay_pkg::QPTR_WIDTH-1:0]     wr_ptr_i,
  input  logic [replay_pkg::QPTR_WIDTH-1:0]     rd_ptr_i,
  input  logic                                  init_i,
  input  logic                                  replay_i,
  input  logic                                  except_i,
  input  logic                                  except_thread_i,
  output logic                                  live_o,
  output logic [replay_pkg::PAGE_WIDTH-1:0]     page_o,
  output logic [replay_pkg::ATTR_WIDTH-1:0]     attr_o
);

  // op payload per entry
  logic [replay_pkg::VADDR_WIDTH-1:0] addr_mem [replay_pkg::QUEUE_DEPTH];
  logic [replay_pkg::SZ_WIDTH-1:0]    sz_mem   [replay_pkg::QUEUE_DEPTH];
  logic [replay_pkg::ATTR_WIDTH-1:0]  attr_mem [replay_pkg::QUEUE_DEPTH];
  logic [replay_pkg::LSQ_WIDTH-1:0]   lsq_mem  [replay_pkg::QUEUE_DEPTH];

  // per-entry miss, thread and invalid bits
  logic [replay_pkg::QUEUE_DEPTH-1:0] miss_q;
  logic [replay_pkg::QUEUE_DEPTH-1:0] thr_q;
  logic [replay_pkg::QUEUE_DEPTH-1:0] inv_q;
  logic [replay_pkg::QPTR_WIDTH-1:0]  rd_ptr_q;

  // registered head view
  replay_pkg::vaddr_u                 head_addr;
  logic [replay_pkg::SZ_WIDTH-1:0]    head_sz;
  logic [replay_pkg::ATTR_WIDTH-1:0]  head_attr;
  logic [replay_pkg::LSQ_WIDTH-1:0]   head_lsq;
  logic                               head_thread;
  logic                               head_live;
  logic                               head_kill;

  // init sweep writes an all-zero op
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      addr_mem[wr_ptr_i] <= init_i ? '0 : op_i.addr.raw;
      sz_mem[wr_ptr_i]   <= init_i ? '0 : op_i.sz;
      attr_mem[wr_ptr_i] <= init_i ? '0 : op_i.attr;
      lsq_mem[wr_ptr_i]  <= init_i ? '0 : op_i.lsq;
    end
    head_addr.raw <= addr_mem[rd_ptr_i];
    head_sz       <= sz_mem[rd_ptr_i];
    head_attr     <= attr_mem[rd_ptr_i];
    head_lsq      <= lsq_mem[rd_ptr_i];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      miss_q   <= '0;
      thr_q    <= '0;
      inv_q    <= '0;
      rd_ptr_q <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_i;
      // thread exception kills every stored op of that thread
      if (except_i) begin
        for (int k = 0; k < replay_pkg::QUEUE_DEPTH; k++) begin
          if (thr_q[k] == except_thread_i) begin
            inv_q[k] <= 1'b1;
          end
        end
      end
      if (wr_en_i) begin
        if (init_i) begin
          miss_q[wr_ptr_i] <= 1'b0;
          thr_q[wr_ptr_i]  <= 1'b0;
          inv_q[wr_ptr_i]  <= 1'b0;
        end else begin
          miss_q[wr_ptr_i] <= miss_i;
          thr_q[wr_ptr_i]  <= op_i.thread;
          // exception in the capture cycle also hits the new entry
          inv_q[wr_ptr_i]  <= except_i && (except_thread_i == op_i.thread);
        end
      end
    end
  end

  // miss and invalid are looked up live so a late exception is seen
  assign head_thread = thr_q[rd_ptr_q];
  assign head_live   = miss_q[rd_ptr_q] & ~inv_q[rd_ptr_q];
  assign head_kill   = except_i & (except_thread_i == head_thread);

  assign live_o = head_live;
  assign page_o = head_addr.split.page;
  assign attr_o = head_attr;

  // replay beat shows the head, otherwise pass through
  assign op_o.en     = replay_i ? (head_live & ~head_kill) : op_i.en;
  assign op_o.thread = replay_i ? head_thread : op_i.thread;
  assign op_o.addr   = replay_i ? head_addr : op_i.addr;
  assign op_o.sz     = replay_i ? head_sz : op_i.sz;
  assign op_o.attr   = replay_i ? head_attr : op_i.attr;
  assign op_o.lsq    = replay_i ? head_lsq : op_i.lsq;

endmodule

// File: hw/replay_ctrl.sv
// ==========================================================================
// Miss replay queue control
// ==========================================================================

`timescale 1ns/100ps

module replay_ctrl (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  miss0_i,
  input  logic                                  miss1_i,
  input  logic                                  mlbreq_ack_i,
  input  logic                                  live0_i,
  input  logic                                  live1_i,
  input  logic [replay_pkg::PAGE_WIDTH-1:0]     page0_i,
  input  logic [replay_pkg::PAGE_WIDTH-1:0]     page1_i,
  input  logic [replay_pkg::ATTR_WIDTH-1:0]     attr0_i,
  input  logic [replay_pkg::ATTR_WIDTH-1:0]     attr1_i,
  output logic                                  wr_en_o,
  output logic [replay_pkg::QPTR_WIDTH-1:0]     wr_ptr_o,
  output logic [replay_pkg::QPTR_WIDTH-1:0]     rd_ptr_o,
  output logic                                  init_o,
  output logic                                  replay_o,
  output logic                                  skip_o,
  output logic                                  mlbreq_en_o,
  output logic [replay_pkg::PAGE_WIDTH-1:0]     mlbreq_page_o,
  output logic [replay_pkg::ATTR_WIDTH-1:0]     mlbreq_attr_o
);

  logic                                  init_q;
  logic [replay_pkg::QPTR_WIDTH-1:0]     init_cnt_q;
  logic [replay_pkg::QPTR_WIDTH-1:0]     wr_ptr_q;
  logic [replay_pkg::QPTR_WIDTH-1:0]     rd_ptr_q;
  logic [replay_pkg::CNT_WIDTH-1:0]      count_q;
  logic [replay_pkg::STATE_WIDTH-1:0]    state_q;
  logic [replay_pkg::STATE_WIDTH-1:0]    state_d;
  logic                                  req_q;
  logic                                  capture;
  logic                                  beat;
  logic                                  in_req;
  logic                                  lane_live;
  logic                                  req_done;

  // misses are dropped while the sweep runs
  assign capture = (miss0_i | miss1_i) & ~init_q;
  assign beat    = (state_q == replay_pkg::ST_BEAT);

  // lane 0 asks first, then lane 1
  assign in_req    = (state_q == replay_pkg::ST_REQ0) | (state_q == replay_pkg::ST_REQ1);
  assign lane_live = (state_q == replay_pkg::ST_REQ1) ? live1_i : live0_i;

  // once raised, the request stays up until ack
  assign mlbreq_en_o = in_req & (lane_live | req_q);
  assign req_done    = ~mlbreq_en_o | mlbreq_ack_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      replay_pkg::ST_SETTLE: begin
        // head view has had a cycle to follow the pointer
        if (count_q != '0) begin
          state_d = replay_pkg::ST_REQ0;
        end
      end
      replay_pkg::ST_REQ0: begin
        if (req_done) begin
          state_d = replay_pkg::ST_REQ1;
        end
      end
      replay_pkg::ST_REQ1: begin
        if (req_done) begin
          state_d = replay_pkg::ST_BEAT;
        end
      end
      default: begin
        state_d = replay_pkg::ST_SETTLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= replay_pkg::ST_SETTLE;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= mlbreq_en_o & ~mlbreq_ack_i;
    end
  end

  // init sweep over all entries after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      init_q     <= 1'b1;
      init_cnt_q <= '0;
    end else if (init_q) begin
      init_cnt_q <= init_cnt_q + 1'b1;
      if (init_cnt_q == replay_pkg::QPTR_WIDTH'(replay_pkg::QUEUE_DEPTH - 1)) begin
        init_q <= 1'b0;
      end
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (capture) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (beat) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({capture, beat})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign wr_en_o  = init_q | capture;
  assign wr_ptr_o = init_q ? init_cnt_q : wr_ptr_q;
  assign rd_ptr_o = rd_ptr_q;
  assign init_o   = init_q;
  assign replay_o = beat;

  // upstream stalls while anything is queued
  assign skip_o = (count_q != '0);

  assign mlbreq_page_o = (state_q == replay_pkg::ST_REQ1) ? page1_i : page0_i;
  assign mlbreq_attr_o = (state_q == replay_pkg::ST_REQ1) ? attr1_i : attr0_i;

endmodule

// File: hw/miss_replay_queue.sv
// ==========================================================================
// Miss replay queue, two lanes
// ==========================================================================

`timescale 1ns/100ps

module miss_replay_queue (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  miss0_i,
  input  logic                                  miss1_i,
  input  logic                                  lane0_en_i,
  input  logic                                  lane0_thread_i,
  input  replay_pkg::vaddr_u                    lane0_addr_i,
  input  logic [replay_pkg::SZ_WIDTH-1:0]       lane0_sz_i,
  input  logic [replay_pkg::ATTR_WIDTH-1:0]     lane0_attr_i,
  input  logic [replay_pkg::LSQ_WIDTH-1:0]      lane0_lsq_i,
  input  logic                                  lane1_en_i,
  input  logic                                  lane1_thread_i,
  input  replay_pkg::vaddr_u                    lane1_addr_i,
  input  logic [replay_pkg::SZ_WIDTH-1:0]       lane1_sz_i,
  input  logic [replay_pkg::ATTR_WIDTH-1:0]     lane1_attr_i,
  input  logic [replay_pkg::LSQ_WIDTH-1:0]      lane1_lsq_i,
  input  logic                                  except_i,
  input  logic                                  except_thread_i,
  input  logic                                  mlbreq_ack_i,
  output logic                                  lane0_en_o,
  output logic                                  lane0_thread_o,
  output replay_pkg::vaddr_u                    lane0_addr_o,
  output logic [replay_pkg::SZ_WIDTH-1:0]       lane0_sz_o,
  output logic [replay_pkg::ATTR_WIDTH-1:0]     lane0_attr_o,
  output logic [replay_pkg::LSQ_WIDTH-1:0]      lane0_lsq_o,
  output logic                                  lane1_en_o,
  output logic                                  lane1_thread_o,
  output replay_pkg::vaddr_u                    lane1_addr_o,
  output logic [replay_pkg::SZ_WIDTH-1:0]       lane1_sz_o,
  output logic [replay_pkg::ATTR_WIDTH-1:0]     lane1_attr_o,
  output logic [replay_pkg::LSQ_WIDTH-1:0]      lane1_lsq_o,
  output logic                                  skip_o,
  output logic                                  mlbreq_en_o,
  output logic [replay_pkg::PAGE_WIDTH-1:0]     mlbreq_page_o,
  output logic [replay_pkg::ATTR_WIDTH-1:0]     mlbreq_attr_o
);

  logic                                  wr_en;
  logic [replay_pkg::QPTR_WIDTH-1:0]     wr_ptr;
  logic [replay_pkg::QPTR_WIDTH-1:0]     rd_ptr;
  logic                                  init;
  logic                                  replay;
  logic                                  live0;
  logic                                  live1;
  logic [replay_pkg::PAGE_WIDTH-1:0]     page0;
  logic [replay_pkg::PAGE_WIDTH-1:0]     page1;
  logic [replay_pkg::ATTR_WIDTH-1:0]     attr0;
  logic [replay_pkg::ATTR_WIDTH-1:0]     attr1;

  mop_lane_if lane0_in_if ();
  mop_lane_if lane0_out_if ();
  mop_lane_if lane1_in_if ();
  mop_lane_if lane1_out_if ();

  // incoming ops
  assign lane0_in_if.en     = lane0_en_i;
  assign lane0_in_if.thread = lane0_thread_i;
  assign lane0_in_if.addr   = lane0_addr_i;
  assign lane0_in_if.sz     = lane0_sz_i;
  assign lane0_in_if.attr   = lane0_attr_i;
  assign lane0_in_if.lsq    = lane0_lsq_i;

  assign lane1_in_if.en     = lane1_en_i;
  assign lane1_in_if.thread = lane1_thread_i;
  assign lane1_in_if.addr   = lane1_addr_i;
  assign lane1_in_if.sz     = lane1_sz_i;
  assign lane1_in_if.attr   = lane1_attr_i;
  assign lane1_in_if.lsq    = lane1_lsq_i;

  // outgoing ops
  assign lane0_en_o     = lane0_out_if.en;
  assign lane0_thread_o = lane0_out_if.thread;
  assign lane0_addr_o   = lane0_out_if.addr;
  assign lane0_sz_o     = lane0_out_if.sz;
  assign lane0_attr_o   = lane0_out_if.attr;
  assign lane0_lsq_o    = lane0_out_if.lsq;

  assign lane1_en_o     = lane1_out_if.en;
  assign lane1_thread_o = lane1_out_if.thread;
  assign lane1_addr_o   = lane1_out_if.addr;
  assign lane1_sz_o     = lane1_out_if.sz;
  assign lane1_attr_o   = lane1_out_if.attr;
  assign lane1_lsq_o    = lane1_out_if.lsq;

  miss_replay_lane lane0 (
    .clk             (clk),
    .rst             (rst),
    .op_i            (lane0_in_if.dst),
    .op_o            (lane0_out_if.src),
    .miss_i          (miss0_i),
    .wr_en_i         (wr_en),
    .wr_ptr_i        (wr_ptr),
    .rd_ptr_i        (rd_ptr),
    .init_i          (init),
    .replay_i        (replay),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .live_o          (live0),
    .page_o          (page0),
    .attr_o          (attr0)
  );

  miss_replay_lane lane1 (
    .clk             (clk),
    .rst             (rst),
    .op_i            (lane1_in_if.dst),
    .op_o            (lane1_out_if.src),
    .miss_i          (miss1_i),
    .wr_en_i         (wr_en),
    .wr_ptr_i        (wr_ptr),
    .rd_ptr_i        (rd_ptr),
    .init_i          (init),
    .replay_i        (replay),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .live_o          (live1),
    .page_o          (page1),
    .attr_o          (attr1)
  );

  replay_ctrl ctrl (
    .clk           (clk),
    .rst           (rst),
    .miss0_i       (miss0_i),
    .miss1_i       (miss1_i),
    .mlbreq_ack_i  (mlbreq_ack_i),
    .live0_i       (live0),
    .live1_i       (live1),
    .page0_i       (page0),
    .page1_i       (page1),
    .attr0_i       (attr0),
    .attr1_i       (attr1),
    .wr_en_o       (wr_en),
    .wr_ptr_o      (wr_ptr),
    .rd_ptr_o      (rd_ptr),
    .init_o        (init),
    .replay_o      (replay),
    .skip_o        (skip_o),
    .mlbreq_en_o   (mlbreq_en_o),
    .mlbreq_page_o (mlbreq_page_o),
    .mlbreq_attr_o (mlbreq_attr_o)
  );

endmodule

// File: tests/miss_replay_queue_asserts.sv
// ==========================================================================
// Miss replay queue request rules
// ==========================================================================

`timescale 1ns/100ps

module miss_replay_queue_asserts (
  input logic                                  clk,
  input logic                                  rst,
  input logic                                  skip_i,
  input logic                                  mlbreq_en_i,
  input logic                                  mlbreq_ack_i,
  input logic [replay_pkg::PAGE_WIDTH-1:0]     mlbreq_page_i,
  input logic [replay_pkg::ATTR_WIDTH-1:0]     mlbreq_attr_i
);

  // an unacknowledged request keeps its page and attr
  req_hold: assert property (
    @(posedge clk) disable iff (rst)
    (mlbreq_en_i && !mlbreq_ack_i) |=>
      (mlbreq_en_i && $stable(mlbreq_page_i) && $stable(mlbreq_attr_i))
  ) else $error("page request dropped or changed before ack");

  // requests only come from a queued entry
  req_needs_skip: assert property (
    @(posedge clk) disable iff (rst)
    mlbreq_en_i |-> skip_i
  ) else $error("page request while skip is low");

  // quiet while in reset
  req_in_reset: assert property (
    @(posedge clk)
    rst |=> !mlbreq_en_i
  ) else $error("page request during reset");

endmodule

// File: tests/miss_replay_queue_tb.sv
// ==========================================================================
// Miss replay queue testbench
// ==========================================================================

`timescale 1ns/100ps

module miss_replay_queue_tb;

  localparam int NUM_TRANS = 600;
  localparam int DEPTH     = replay_pkg::QUEUE_DEPTH;

  logic clk;
  logic rst;
  logic miss0;
  logic miss1;
  logic except_en;
  logic except_thr;
  logic ack;
  logic skip;
  logic req_en;
  logic [replay_pkg::PAGE_WIDTH-1:0] req_page;
  logic [replay_pkg::ATTR_WIDTH-1:0] req_attr;

  // lane inputs and outputs, index is the lane
  logic                              in_en [2];
  logic                              in_thr [2];
  replay_pkg::vaddr_u                in_addr [2];
  logic [replay_pkg::SZ_WIDTH-1:0]   in_sz [2];
  logic [replay_pkg::ATTR_WIDTH-1:0] in_attr [2];
  logic [replay_pkg::LSQ_WIDTH-1:0]  in_lsq [2];
  logic                              out_en [2];
  logic                              out_thr [2];
  replay_pkg::vaddr_u                out_addr [2];
  logic [replay_pkg::SZ_WIDTH-1:0]   out_sz [2];
  logic [replay_pkg::ATTR_WIDTH-1:0] out_attr [2];
  logic [replay_pkg::LSQ_WIDTH-1:0]  out_lsq [2];

  // reference model of the queue
  logic                              m_miss [2][DEPTH];
  logic                              m_inv [2][DEPTH];
  logic                              m_thr [2][DEPTH];
  replay_pkg::vaddr_u                m_addr [2][DEPTH];
  logic [replay_pkg::SZ_WIDTH-1:0]   m_sz [2][DEPTH];
  logic [replay_pkg::ATTR_WIDTH-1:0] m_attr [2][DEPTH];
  logic [replay_pkg::LSQ_WIDTH-1:0]  m_lsq [2][DEPTH];
  int hd;
  int tl;
  int count;
  int captures;
  int next_lane;
  int held_lane;
  logic held;
  int ack_cnt;
  logic checking;

  miss_replay_queue dut0 (
    .clk(clk), .rst(rst), .miss0_i(miss0), .miss1_i(miss1),
    .lane0_en_i(in_en[0]), .lane0_thread_i(in_thr[0]), .lane0_addr_i(in_addr[0]),
    .lane0_sz_i(in_sz[0]), .lane0_attr_i(in_attr[0]), .lane0_lsq_i(in_lsq[0]),
    .lane1_en_i(in_en[1]), .lane1_thread_i(in_thr[1]), .lane1_addr_i(in_addr[1]),
    .lane1_sz_i(in_sz[1]), .lane1_attr_i(in_attr[1]), .lane1_lsq_i(in_lsq[1]),
    .except_i(except_en), .except_thread_i(except_thr), .mlbreq_ack_i(ack),
    .lane0_en_o(out_en[0]), .lane0_thread_o(out_thr[0]), .lane0_addr_o(out_addr[0]),
    .lane0_sz_o(out_sz[0]), .lane0_attr_o(out_attr[0]), .lane0_lsq_o(out_lsq[0]),
    .lane1_en_o(out_en[1]), .lane1_thread_o(out_thr[1]), .lane1_addr_o(out_addr[1]),
    .lane1_sz_o(out_sz[1]), .lane1_attr_o(out_attr[1]), .lane1_lsq_o(out_lsq[1]),
    .skip_o(skip), .mlbreq_en_o(req_en), .mlbreq_page_o(req_page),
    .mlbreq_attr_o(req_attr)
  );

  bind miss_replay_queue miss_replay_queue_asserts asrt0 (
    .clk(clk), .rst(rst), .skip_i(skip_o), .mlbreq_en_i(mlbreq_en_o),
    .mlbreq_ack_i(mlbreq_ack_i), .mlbreq_page_i(mlbreq_page_o),
    .mlbreq_attr_i(mlbreq_attr_o)
  );

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_addr(input string name, input replay_pkg::vaddr_u got,
                              input replay_pkg::vaddr_u exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s got %h exp %h", name, got.raw, exp.raw));
    end
  endtask

  task automatic compare_page(input string name,
                              input logic [replay_pkg::PAGE_WIDTH-1:0] got,
                              input logic [replay_pkg::PAGE_WIDTH-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic compare_attr(input string name,
                              input logic [replay_pkg::ATTR_WIDTH-1:0] got,
                              input logic [replay_pkg::ATTR_WIDTH-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic compare_sz(input string name, input logic [replay_pkg::SZ_WIDTH-1:0] got,
                            input logic [replay_pkg::SZ_WIDTH-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic compare_lsq(input string name, input logic [replay_pkg::LSQ_WIDTH-1:0] got,
                             input logic [replay_pkg::LSQ_WIDTH-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s got %h exp %h", name, got, exp));
    end
  endtask

  function automatic logic lane_live(input int l);
    return m_miss[l][hd] && !m_inv[l][hd];
  endfunction

  // the head entry on both lanes, different from what comes in
  function automatic logic head_shown();
    logic same;
    logic differs;
    same = 1'b1;
    differs = 1'b0;
    for (int l = 0; l < 2; l++) begin
      same &= (out_thr[l] === m_thr[l][hd]) && (out_addr[l] === m_addr[l][hd]) &&
              (out_sz[l] === m_sz[l][hd]) && (out_attr[l] === m_attr[l][hd]) &&
              (out_lsq[l] === m_lsq[l][hd]);
      differs |= (out_addr[l] !== in_addr[l]);
    end
    return same && differs;
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // check outputs mid-cycle, then advance the model over the next edge
  always @(negedge clk) begin
    logic beat;
    int lane;
    if (checking) begin
      beat = (count > 0) && head_shown();
      compare_flag("skip_o", skip, count != 0);
      for (int l = 0; l < 2; l++) begin
        if (beat) begin
          compare_flag($sformatf("lane%0d_en_o", l), out_en[l], lane_live(l) &&
                       !(except_en && except_thr == m_thr[l][hd]));
          if (lane_live(l) && l >= next_lane) begin
            stop_run($sformatf("lane %0d replayed before its page request", l));
          end
        end else begin
          compare_flag($sformatf("lane%0d_en_o", l), out_en[l], in_en[l]);
          compare_flag($sformatf("lane%0d_thread_o", l), out_thr[l], in_thr[l]);
          compare_addr($sformatf("lane%0d_addr_o", l), out_addr[l], in_addr[l]);
          compare_sz($sformatf("lane%0d_sz_o", l), out_sz[l], in_sz[l]);
          compare_attr($sformatf("lane%0d_attr_o", l), out_attr[l], in_attr[l]);
          compare_lsq($sformatf("lane%0d_lsq_o", l), out_lsq[l], in_lsq[l]);
        end
      end
      if (req_en) begin
        if (count == 0) begin
          stop_run("page request while the queue is empty");
        end
        lane = held ? held_lane : next_lane;
        if (!held && lane == 0 && !lane_live(0)) begin
          lane = 1;
        end
        if (lane > 1 || (!held && !lane_live(lane))) begin
          stop_run("page request without a live op at the head");
        end
        compare_page("mlbreq_page_o", req_page, m_addr[lane][hd].split.page);
        compare_attr("mlbreq_attr_o", req_attr, m_attr[lane][hd]);
        if (ack) begin
          next_lane = lane + 1;
          held = 1'b0;
          ack_cnt = int'($urandom % 4);
        end else begin
          held = 1'b1;
          held_lane = lane;
          if (ack_cnt > 0) begin
            ack_cnt--;
          end
        end
      end
      if (except_en) begin
        for (int l = 0; l < 2; l++) begin
          for (int i = 0; i < DEPTH; i++) begin
            if (m_thr[l][i] == except_thr) begin
              m_inv[l][i] = 1'b1;
            end
          end
        end
      end
      if (beat) begin
        hd = (hd + 1) % DEPTH;
        count--;
        next_lane = 0;
      end
      if (miss0 || miss1) begin
        for (int l = 0; l < 2; l++) begin
          m_miss[l][tl] = (l == 0) ? miss0 : miss1;
          m_inv[l][tl]  = except_en && (except_thr == in_thr[l]);
          m_thr[l][tl]  = in_thr[l];
          m_addr[l][tl] = in_addr[l];
          m_sz[l][tl]   = in_sz[l];
          m_attr[l][tl] = in_attr[l];
          m_lsq[l][tl]  = in_lsq[l];
        end
        tl = (tl + 1) % DEPTH;
        count++;
        captures++;
      end
    end
  end

  initial begin
    #(NUM_TRANS * 20 * 10);
    $display("timeout: the queue did not finish its transactions in time");
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [63:0] r;
    void'($urandom(32'hdd738b85));
    {hd, tl, count, captures, next_lane, held_lane, ack_cnt} = '0;
    held = 1'b0;
    checking = 1'b0;
    {rst, miss0, miss1, except_en, except_thr, ack} = 6'b100000;
    for (int l = 0; l < 2; l++) begin
      {in_en[l], in_thr[l], in_sz[l], in_attr[l], in_lsq[l]} = '0;
      in_addr[l] = '0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    // room for the init sweep
    repeat (5) @(posedge clk);
    @(negedge clk);
    compare_flag("skip_o", skip, 1'b0);
    compare_flag("mlbreq_en_o", req_en, 1'b0);
    compare_flag("lane0_en_o", out_en[0], 1'b0);
    compare_flag("lane1_en_o", out_en[1], 1'b0);
    checking = 1'b1;
    while (captures < NUM_TRANS) begin
      @(posedge clk);
      for (int l = 0; l < 2; l++) begin
        r = {$urandom, $urandom};
        in_en[l]   <= r[63];
        in_thr[l]  <= r[62];
        in_addr[l] <= r[replay_pkg::VADDR_WIDTH-1:0];
        in_sz[l]   <= r[53 +: replay_pkg::SZ_WIDTH];
        in_attr[l] <= r[58 +: replay_pkg::ATTR_WIDTH];
        in_lsq[l]  <= r[44 +: replay_pkg::LSQ_WIDTH];
      end
      r = {$urandom, $urandom};
      miss0      <= (count < DEPTH) && (r[1:0] == 2'd0);
      miss1      <= (count < DEPTH) && (r[3:2] == 2'd0);
      except_en  <= (r[7:4] == 4'd0);
      except_thr <= r[8];
      ack        <= (ack_cnt == 0);
    end
    @(posedge clk);
    miss0 <= 1'b0;
    miss1 <= 1'b0;
    except_en <= 1'b0;
    while (count != 0) begin
      @(posedge clk);
      ack <= (ack_cnt == 0);
    end
    repeat (3) @(negedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

// File: miss_replay_queue.f
hw/replay_pkg.sv
hw/mop_lane_if.sv
hw/miss_replay_lane.sv
hw/replay_ctrl.sv
hw/miss_replay_queue.sv
tests/miss_replay_queue_asserts.sv
tests/miss_replay_queue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the miss replay queue simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module miss_replay_queue_tb \
  -f miss_replay_queue.f \
  -o miss_replay_queue_sim

./obj_dir/miss_replay_queue_sim
